// ==== src.f ====
rtl/ts_pkg.sv
rtl/ts_ram.sv
rtl/ts_regs.sv
rtl/ts_tile_fetch.sv
rtl/ts_sprite_fetch.sv
rtl/video_ts.sv
rtl/ts_top.sv
dv/ts_tb.sv

// ==== dv/ts_tb.sv ====
`timescale 1ns/1ps

module ts_tb
	import ts_pkg::*;
;

	localparam int N_SPRITES   = (LAST_SREG + 1) / 3;
	localparam int LINE_CYCLES = 2000;
	localparam int N_LINES     = 9;
	// three clocks per APB access, two sprite file loads and one tilemap load
	localparam int APB_CYCLES  = 3 * (TMB_WORDS + 2 * SFILE_WORDS) + 1000;
	localparam int WATCHDOG_NS = (16 + N_LINES * LINE_CYCLES + APB_CYCLES) * 100;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        start;
	logic [8:0]  line;
	logic        tsr_go;
	tsr_task_t   tsr_task;
	logic        tsr_rdy;
	logic        line_done;

	// reference copies of what the DUT holds
	ts_cfg_t     cfg_m;
	sfile_word_t sfile_m [SFILE_WORDS];
	tile_desc_t  tmb_m [TMB_WORDS];
	tsr_task_t   exp_q [$];

	int val_errs;
	int proto_errs;

	ts_top #(
		.SFILE_DEPTH (SFILE_WORDS),
		.TMB_DEPTH   (TMB_WORDS)
	) dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.start     (start),
		.line      (line),
		.tsr_go    (tsr_go),
		.tsr_task  (tsr_task),
		.tsr_rdy   (tsr_rdy),
		.line_done (line_done)
	);

	always #50 clk = ~clk;

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, the run did not complete", $time);
		$display("Finished with errors");
		$finish;
	end

	task automatic check_task(input tsr_task_t got, input tsr_task_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			val_errs++;
		end
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
			val_errs++;
		end
	endtask

	task automatic check_err(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s pslverr got %b expected %b", $time, what, got, exp);
			val_errs++;
		end
	endtask

	task automatic check_ready(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s pready got %b expected %b", $time, what, got, exp);
			val_errs++;
		end
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		err = pslverr;
		// zero wait states on every access
		check_ready(pready, 1'b1, $sformatf("write %h", addr));
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		data = prdata;
		err  = pslverr;
		check_ready(pready, 1'b1, $sformatf("read %h", addr));
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_ok(input logic [11:0] addr, input logic [31:0] data);
		logic err;
		apb_write(addr, data, err);
		check_err(err, 1'b0, $sformatf("write %h", addr));
	endtask

	task automatic write_cfg();
		write_ok(12'h000, {27'd0, cfg_m.t1z_en, cfg_m.t0z_en, cfg_m.t1_en, cfg_m.t0_en,
			cfg_m.s_en});
		write_ok(12'h004, {8'd0, cfg_m.sgpage, cfg_m.t1gpage, cfg_m.t0gpage});
		write_ok(12'h008, {26'd0, cfg_m.num_tiles});
		write_ok(12'h00C, {6'd0, cfg_m.t0_palsel, 5'd0, cfg_m.t0y_offs, 7'd0, cfg_m.t0x_offs});
		write_ok(12'h010, {6'd0, cfg_m.t1_palsel, 5'd0, cfg_m.t1y_offs, 7'd0, cfg_m.t1x_offs});
	endtask

	// random offsets, pages and palettes for both planes
	task automatic shuffle_cfg();
		cfg_m.t0gpage   = 8'($urandom);
		cfg_m.t1gpage   = 8'($urandom);
		cfg_m.sgpage    = 8'($urandom);
		cfg_m.t0x_offs  = 9'($urandom);
		cfg_m.t1x_offs  = 9'($urandom);
		cfg_m.t0y_offs  = 3'($urandom);
		cfg_m.t1y_offs  = 3'($urandom);
		cfg_m.t0_palsel = 2'($urandom);
		cfg_m.t1_palsel = 2'($urandom);
	endtask

	task automatic load_tiles();
		tile_desc_t d;
		for (int i = 0; i < TMB_WORDS; i++)
		begin
			d = tile_desc_t'(16'($urandom));
			// about a quarter of the map is empty
			if ($urandom_range(0, 3) == 0)
				d.tnum = '0;
			tmb_m[i] = d;
			write_ok({1'b1, 9'(i), 2'b00}, {16'd0, d});
		end
	endtask

	task automatic load_sprites(input logic [8:0] base, input int leap_a, input int leap_b,
		input int leap_c);
		spr_r0_t r0;
		spr_r1_t r1;
		spr_r2_t r2;
		for (int s = 0; s < N_SPRITES; s++)
		begin
			r0      = spr_r0_t'(16'($urandom));
			// ycrd just above base so that many sprites cross it
			r0.ycrd = 9'(base - $urandom_range(0, 70));
			r0.act  = ($urandom_range(0, 3) != 0);
			r0.leap = (s == leap_a) || (s == leap_b) || (s == leap_c);
			r1      = spr_r1_t'(16'($urandom));
			r2      = spr_r2_t'(16'($urandom));
			sfile_m[3 * s]     = r0;
			sfile_m[3 * s + 1] = r1;
			sfile_m[3 * s + 2] = r2;
			write_ok({2'b01, 8'(3 * s), 2'b00}, {16'd0, r0});
			write_ok({2'b01, 8'(3 * s + 1), 2'b00}, {16'd0, r1});
			write_ok({2'b01, 8'(3 * s + 2), 2'b00}, {16'd0, r2});
		end
	endtask

	// sprites whose leap count before them equals the layer number
	task automatic model_sprites(input logic [8:0] ln, input int layer);
		spr_r0_t   r0;
		spr_r1_t   r1;
		spr_r2_t   r2;
		tsr_task_t t;
		int        lcnt;
		int        d;
		int        ymax;
		int        off;
		lcnt = 0;
		if (!cfg_m.s_en)
			return;
		for (int s = 0; s < N_SPRITES; s++)
		begin
			r0   = spr_r0_t'(sfile_m[3 * s]);
			r1   = spr_r1_t'(sfile_m[3 * s + 1]);
			r2   = spr_r2_t'(sfile_m[3 * s + 2]);
			d    = (int'(ln) - int'(r0.ycrd)) & 511;
			ymax = int'(r0.ysz) * 8 + 7;
			if (lcnt == layer && r0.act && d <= ymax)
			begin
				off    = r0.yflp ? ymax - d : d;
				t.addr = r2.tnum[5:0];
				t.line = 9'(int'(r2.tnum[11:6]) * 8 + off);
				t.page = cfg_m.sgpage;
				t.x    = r1.xcrd;
				t.xs   = r1.xsz;
				t.xf   = r1.xflp;
				t.pal  = r2.pal;
				exp_q.push_back(t);
			end
			if (r0.leap)
				lcnt++;
		end
	endtask

	task automatic model_tiles(input logic [8:0] ln, input logic p);
		logic [8:0] lt;
		logic [8:0] txo;
		logic [5:0] col;
		logic [8:0] addr;
		logic       zen;
		tile_desc_t d;
		tsr_task_t  t;
		if (!(p ? cfg_m.t1_en : cfg_m.t0_en))
			return;
		txo = p ? cfg_m.t1x_offs : cfg_m.t0x_offs;
		zen = p ? cfg_m.t1z_en : cfg_m.t0z_en;
		lt  = ln + (p ? cfg_m.t1y_offs : cfg_m.t0y_offs);
		for (int k = 0; k <= int'(cfg_m.num_tiles); k++)
		begin
			col  = 6'(int'(txo[8:3]) + k);
			addr = {lt[4:3], col, p};
			d    = tmb_m[addr];
			if (d.tnum != 12'd0 || zen)
			begin
				t.addr = d.tnum[5:0];
				t.line = {d.tnum[11:6], lt[2:0] ^ {3{d.yflp}}};
				t.page = p ? cfg_m.t1gpage : cfg_m.t0gpage;
				t.x    = 9'(8 * k - int'(txo[2:0]));
				t.xs   = 3'd0;
				t.xf   = d.xflp;
				t.pal  = {p ? cfg_m.t1_palsel : cfg_m.t0_palsel, d.pal};
				exp_q.push_back(t);
			end
		end
	endtask

	task automatic run_line(input logic [8:0] ln, input bit stall, input string name);
		tsr_task_t got_q [$];
		bit        done;
		int        cyc;
		int        n;
		exp_q.delete();
		model_sprites(ln, 0);
		model_tiles(ln, 1'b0);
		model_sprites(ln, 1);
		model_tiles(ln, 1'b1);
		model_sprites(ln, 2);
		done = 1'b0;
		cyc  = 0;
		@(posedge clk);
		#1;
		start   = 1'b1;
		line    = ln;
		tsr_rdy = 1'b1;
		while (!done && cyc < LINE_CYCLES)
		begin
			@(negedge clk);
			if (tsr_go && !tsr_rdy)
			begin
				$display("%s: tsr_go raised while tsr_rdy was low at %0t", name, $time);
				proto_errs++;
			end
			if (tsr_go)
				got_q.push_back(tsr_task);
			if (line_done)
				done = 1'b1;
			@(posedge clk);
			#1;
			start   = 1'b0;
			tsr_rdy = stall ? ($urandom_range(0, 3) != 0) : 1'b1;
			cyc++;
		end
		tsr_rdy = 1'b1;
		if (!done)
		begin
			$display("%s: line_done did not arrive within %0d cycles", name, LINE_CYCLES);
			proto_errs++;
		end
		if (got_q.size() != exp_q.size())
		begin
			$display("%s: expected %0d render tasks but received %0d", name, exp_q.size(),
				got_q.size());
			proto_errs++;
		end
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++)
			check_task(got_q[i], exp_q[i], $sformatf("%s task %0d", name, i));
		$display("%s: %0d tasks in %0d cycles", name, got_q.size(), cyc);
	endtask

	function automatic logic [31:0] reg_mask(input int idx);
		case (idx)
			0: return 32'h0000_001F;
			1: return 32'h00FF_FFFF;
			2: return 32'h0000_003F;
			default: return 32'h0307_01FF;
		endcase
	endfunction

	task automatic test_apb();
		logic [31:0] wd;
		logic [31:0] rd;
		logic        err;
		logic [11:0] bad [4];
		bad = '{12'h404, 12'h9A8, 12'h014, 12'h03C};
		for (int i = 0; i < 5; i++)
		begin
			wd = $urandom;
			write_ok(12'(i * 4), wd);
			apb_read(12'(i * 4), rd, err);
			check_word(rd, wd & reg_mask(i), $sformatf("cfg reg %0d readback", i));
			check_err(err, 1'b0, $sformatf("cfg reg %0d read", i));
		end
		// RAM regions and holes answer with an error and zero data
		for (int i = 0; i < 4; i++)
		begin
			apb_read(bad[i], rd, err);
			check_word(rd, 32'd0, $sformatf("read %h data", bad[i]));
			check_err(err, 1'b1, $sformatf("read %h", bad[i]));
		end
		apb_write(12'h020, 32'hFFFF_FFFF, err);
		check_err(err, 1'b1, "write to hole 020");
	endtask

	task automatic test_tiles();
		load_tiles();
		cfg_m           = '0;
		cfg_m.t0_en     = 1'b1;
		cfg_m.t1_en     = 1'b1;
		cfg_m.t1z_en    = 1'b1;
		shuffle_cfg();
		cfg_m.num_tiles = 6'd40;
		write_cfg();
		run_line(9'd37, 1'b0, "tiles a");
		shuffle_cfg();
		cfg_m.t0z_en    = 1'b1;
		cfg_m.t1z_en    = 1'b0;
		cfg_m.num_tiles = 6'd63;
		write_cfg();
		run_line(9'd130, 1'b0, "tiles b");
		// single column at the last line
		shuffle_cfg();
		cfg_m.num_tiles = 6'd0;
		write_cfg();
		run_line(9'd511, 1'b0, "tiles c");
	endtask

	task automatic test_sprites();
		load_sprites(9'd3, -1, -1, -1);
		cfg_m      = '0;
		shuffle_cfg();
		cfg_m.s_en = 1'b1;
		write_cfg();
		// ycrd values wrap below zero around line 3
		run_line(9'd3, 1'b0, "sprites wrap");
		run_line(9'd40, 1'b0, "sprites low");
	endtask

	task automatic test_full_line();
		load_sprites(9'd250, 20, 45, 70);
		cfg_m.s_en      = 1'b1;
		cfg_m.t0_en     = 1'b1;
		cfg_m.t1_en     = 1'b1;
		cfg_m.t0z_en    = 1'b0;
		cfg_m.t1z_en    = 1'b0;
		cfg_m.num_tiles = 6'd39;
		shuffle_cfg();
		write_cfg();
		run_line(9'd250, 1'b0, "full line");
		cfg_m.t0_en = 1'b0;
		write_cfg();
		run_line(9'd260, 1'b0, "plane 0 off");
	endtask

	task automatic test_backpressure();
		cfg_m.t0_en  = 1'b1;
		cfg_m.t1z_en = 1'b1;
		shuffle_cfg();
		write_cfg();
		run_line(9'd250, 1'b1, "stall a");
		run_line(9'd230, 1'b1, "stall b");
	endtask

	initial
	begin
		int unsigned seed;
		seed       = 32'h9dd7_39db;
		void'($urandom(seed));
		val_errs   = 0;
		proto_errs = 0;
		clk        = 1'b0;
		rst_n      = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		start      = 1'b0;
		line       = '0;
		tsr_rdy    = 1'b1;
		cfg_m      = '0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		if (tsr_go !== 1'b0 || line_done !== 1'b0 || pslverr !== 1'b0)
		begin
			$display("outputs are not idle after reset");
			proto_errs++;
		end
		test_apb();
		test_tiles();
		test_sprites();
		test_full_line();
		test_backpressure();
		$display("errors: %0d value mismatches, %0d protocol failures", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== rtl/ts_top.sv ====
`timescale 1ns/1ps

module ts_top
	import ts_pkg::*;
#(
	parameter int SFILE_DEPTH = SFILE_WORDS,
	parameter int TMB_DEPTH = TMB_WORDS
)(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic        start,
	input  logic [8:0]  line,
	output logic        tsr_go,
	output tsr_task_t   tsr_task,
	input  logic        tsr_rdy,
	output logic        line_done
);

	ts_cfg_t     cfg;
	logic        sfile_we;
	logic [7:0]  sfile_waddr;
	sfile_word_t sfile_wdata;
	logic        tmb_we;
	logic [8:0]  tmb_waddr;
	tile_desc_t  tmb_wdata;
	logic [8:0]  tmb_raddr;
	tile_desc_t  tmb_rdata;

	ts_regs regs_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.cfg         (cfg),
		.sfile_we    (sfile_we),
		.sfile_waddr (sfile_waddr),
		.sfile_wdata (sfile_wdata),
		.tmb_we      (tmb_we),
		.tmb_waddr   (tmb_waddr),
		.tmb_wdata   (tmb_wdata)
	);

	// tilemap line buffer
	ts_ram #(
		.entry_t (tile_desc_t),
		.DEPTH   (TMB_DEPTH)
	) tmb_i (
		.clk     (clk),
		.wr_en   (tmb_we),
		.wr_addr (tmb_waddr),
		.wr_data (tmb_wdata),
		.rd_addr (tmb_raddr),
		.rd_data (tmb_rdata)
	);

	video_ts #(
		.SFILE_DEPTH (SFILE_DEPTH)
	) ts_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.line        (line),
		.cfg         (cfg),
		.sfile_we    (sfile_we),
		.sfile_waddr (sfile_waddr),
		.sfile_wdata (sfile_wdata),
		.tmb_raddr   (tmb_raddr),
		.tmb_rdata   (tmb_rdata),
		.tsr_go      (tsr_go),
		.tsr_task    (tsr_task),
		.tsr_rdy     (tsr_rdy),
		.line_done   (line_done)
	);

endmodule

// ==== rtl/video_ts.sv ====
`timescale 1ns/1ps

module video_ts
	import ts_pkg::*;
#(
	parameter int SFILE_DEPTH = SFILE_WORDS
)(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic [8:0]  line,
	input  ts_cfg_t     cfg,
	input  logic        sfile_we,
	input  logic [7:0]  sfile_waddr,
	input  sfile_word_t sfile_wdata,
	output logic [8:0]  tmb_raddr,
	input  tile_desc_t  tmb_rdata,
	output logic        tsr_go,
	output tsr_task_t   tsr_task,
	input  logic        tsr_rdy,
	output logic        line_done
);

	logic [4:0]  layer_r;
	logic [4:0]  ended_r;
	logic [4:0]  layer_dis;
	logic [4:0]  layer_skip;
	logic [4:0]  layer_act;
	logic [4:0]  layer_fin;
	logic        advance;
	logic        spr_on;
	logic        tile_on;
	logic        spr_rdy;
	logic        plane;
	logic        tile_go;
	logic [8:0]  line_r;
	logic [8:0]  line_q;
	logic [7:0]  sfile_raddr;
	sfile_word_t sfile_rdata;
	logic        s_valid;
	logic        s_lend;
	logic        s_aend;
	logic        s_end;
	tsr_task_t   s_task;
	logic        t_valid;
	logic        t_lend;
	tsr_task_t   t_task;

	assign line_q = start ? line : line_r;

	// order: sprites 0, tiles 0, sprites 1, tiles 1, sprites 2
	assign s_end      = s_lend || s_aend;
	assign layer_dis  = {!cfg.s_en, !cfg.t1_en, !cfg.s_en, !cfg.t0_en, !cfg.s_en};
	assign layer_skip = layer_dis | ended_r;
	assign layer_act  = layer_r & ~layer_skip;
	assign layer_fin  = layer_r & {s_end, t_lend, s_end, t_lend, s_end};
	assign advance    = (|(layer_r & layer_skip)) || (|layer_fin);

	assign spr_on  = layer_act[0] || layer_act[2] || layer_act[4];
	assign tile_on = layer_act[1] || layer_act[3];
	assign spr_rdy = tsr_rdy && spr_on;
	assign plane   = layer_r[2] || layer_r[3];
	// tile fetch armed one cycle ahead of its layer
	assign tile_go = advance && !start &&
		((layer_r[0] && cfg.t0_en) || (layer_r[2] && cfg.t1_en));

	assign tsr_go   = tsr_rdy && ((spr_on && s_valid) || (tile_on && t_valid));
	assign tsr_task = spr_on ? s_task : t_task;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			layer_r   <= '0;
			ended_r   <= '0;
			line_r    <= '0;
			line_done <= 1'b0;
		end
		else
		begin
			line_done <= advance && layer_r[4] && !start;
			if (start)
			begin
				layer_r <= 5'b00001;
				ended_r <= '0;
				line_r  <= line;
			end
			else
			begin
				if (advance)
					layer_r <= {layer_r[3:0], 1'b0};
				// end of sprite file closes every later sprite layer
				if (s_aend)
					ended_r <= ended_r | 5'b10101;
			end
		end
	end

	ts_sprite_fetch spr_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.go_line     (start),
		.line        (line_q),
		.cfg         (cfg),
		.tsr_rdy     (spr_rdy),
		.sfile_raddr (sfile_raddr),
		.sfile_rdata (sfile_rdata),
		.task_valid  (s_valid),
		.task_out    (s_task),
		.layer_end   (s_lend),
		.all_end     (s_aend)
	);

	ts_tile_fetch tile_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.go_layer   (tile_go),
		.plane      (plane),
		.cfg        (cfg),
		.line       (line_q),
		.tsr_rdy    (tsr_rdy),
		.tmb_raddr  (tmb_raddr),
		.tmb_rdata  (tmb_rdata),
		.task_valid (t_valid),
		.task_out   (t_task),
		.layer_end  (t_lend)
	);

	ts_ram #(
		.entry_t (sfile_word_t),
		.DEPTH   (SFILE_DEPTH)
	) sfile_i (
		.clk     (clk),
		.wr_en   (sfile_we),
		.wr_addr (sfile_waddr),
		.wr_data (sfile_wdata),
		.rd_addr (sfile_raddr),
		.rd_data (sfile_rdata)
	);

endmodule

// ==== rtl/ts_sprite_fetch.sv ====
`timescale 1ns/1ps

module ts_sprite_fetch
	import ts_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        go_line,
	input  logic [8:0]  line,
	input  ts_cfg_t     cfg,
	input  logic        tsr_rdy,
	output logic [7:0]  sfile_raddr,
	input  sfile_word_t sfile_rdata,
	output logic        task_valid,
	output tsr_task_t   task_out,
	output logic        layer_end,
	output logic        all_end
);

	localparam logic [1:0] PH_R0 = 2'd0;
	localparam logic [1:0] PH_R1 = 2'd1;
	localparam logic [1:0] PH_R2 = 2'd2;

	logic       run;
	logic [1:0] phase;
	logic [7:0] sreg_r;
	logic [7:0] sreg_nxt;
	logic       leap_r;
	logic [5:0] off_r;
	logic [8:0] xcrd_r;
	logic [2:0] xsz_r;
	logic       xflp_r;
	spr_r0_t    r0;
	spr_r2_t    r2;
	spr_r1_t    r1;
	logic [8:0] s_dist;
	logic [5:0] s_ymax;
	logic       s_vis;
	logic       adv;
	logic       r0_skip;
	logic       r2_go;

	assign r0 = sfile_rdata;
	assign r1 = sfile_rdata;
	assign r2 = sfile_rdata;

	// Y test, wraps modulo 512
	assign s_dist = line - r0.ycrd;
	assign s_ymax = {r0.ysz, 3'b111};
	assign s_vis  = r0.act && (s_dist <= {3'd0, s_ymax});

	// everything holds while the renderer is busy
	assign adv     = run && tsr_rdy;
	assign r0_skip = adv && (phase == PH_R0) && !s_vis;
	assign r2_go   = adv && (phase == PH_R2);

	assign task_valid = run && (phase == PH_R2);
	assign layer_end  = (r0_skip && r0.leap) || (r2_go && leap_r);
	assign all_end    = (r0_skip && (sreg_r == 8'(LAST_SREG - 2))) ||
		(r2_go && (sreg_r == 8'(LAST_SREG)));

	always_comb
	begin
		if (go_line)
			sreg_nxt = '0;
		else if (r0_skip)
			sreg_nxt = sreg_r + 8'd3;
		else if (adv)
			sreg_nxt = sreg_r + 8'd1;
		else
			sreg_nxt = sreg_r;
	end

	assign sfile_raddr = sreg_nxt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run    <= 1'b0;
			phase  <= PH_R0;
			sreg_r <= '0;
		end
		else
		begin
			sreg_r <= sreg_nxt;
			if (go_line)
			begin
				run   <= 1'b1;
				phase <= PH_R0;
			end
			else if (adv)
			begin
				if (all_end)
					run <= 1'b0;
				case (phase)
					PH_R0: phase <= s_vis ? PH_R1 : PH_R0;
					PH_R1: phase <= PH_R2;
					default: phase <= PH_R0;
				endcase
			end
		end
	end

	// R0 and R1 fields kept until R2 arrives
	always_ff @(posedge clk)
	begin
		if (adv && (phase == PH_R0))
		begin
			leap_r <= r0.leap;
			off_r  <= r0.yflp ? (s_ymax - s_dist[5:0]) : s_dist[5:0];
		end
		if (adv && (phase == PH_R1))
		begin
			xcrd_r <= r1.xcrd;
			xsz_r  <= r1.xsz;
			xflp_r <= r1.xflp;
		end
	end

	always_comb
	begin
		task_out.addr = r2.tnum[5:0];
		task_out.line = {r2.tnum[11:6], 3'd0} + {3'd0, off_r};
		task_out.page = cfg.sgpage;
		task_out.x    = xcrd_r;
		task_out.xs   = xsz_r;
		task_out.xf   = xflp_r;
		task_out.pal  = r2.pal;
	end

endmodule

// ==== rtl/ts_tile_fetch.sv ====
`timescale 1ns/1ps

module ts_tile_fetch
	import ts_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       go_layer,
	input  logic       plane,
	input  ts_cfg_t    cfg,
	input  logic [8:0] line,
	input  logic       tsr_rdy,
	output logic [8:0] tmb_raddr,
	input  tile_desc_t tmb_rdata,
	output logic       task_valid,
	output tsr_task_t  task_out,
	output logic       layer_end
);

	logic       active;
	logic [5:0] col_r;
	logic [5:0] tpos_r;
	logic [5:0] tpos_nxt;
	logic [8:0] tx_offs;
	logic [2:0] ty_offs;
	logic [8:0] t_line;
	logic       zero_en;
	logic       t_act;
	logic       step;
	logic       last_col;

	// per-plane settings
	assign tx_offs = plane ? cfg.t1x_offs : cfg.t0x_offs;
	assign ty_offs = plane ? cfg.t1y_offs : cfg.t0y_offs;
	assign zero_en = plane ? cfg.t1z_en : cfg.t0z_en;
	assign t_line  = line + {6'd0, ty_offs};

	// empty tiles are stepped over unless zero tiles are enabled
	assign t_act      = (tmb_rdata.tnum != 12'd0) || zero_en;
	assign step       = active && tsr_rdy;
	assign last_col   = (col_r == cfg.num_tiles);
	assign layer_end  = step && last_col;
	assign task_valid = active && t_act;

	// tilemap position wraps at 64
	assign tpos_nxt  = go_layer ? tx_offs[8:3] : tpos_r + {5'd0, step};
	assign tmb_raddr = {t_line[4:3], tpos_nxt, plane};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			col_r  <= '0;
			tpos_r <= '0;
		end
		else
		begin
			tpos_r <= tpos_nxt;
			if (go_layer)
			begin
				active <= 1'b1;
				col_r  <= '0;
			end
			else if (step)
			begin
				if (last_col)
					active <= 1'b0;
				else
					col_r <= col_r + 6'd1;
			end
		end
	end

	always_comb
	begin
		task_out.addr = tmb_rdata.tnum[5:0];
		task_out.line = {tmb_rdata.tnum[11:6], t_line[2:0] ^ {3{tmb_rdata.yflp}}};
		task_out.page = plane ? cfg.t1gpage : cfg.t0gpage;
		// fine X scroll shifts the whole row left
		task_out.x    = {col_r, 3'd0} - {6'd0, tx_offs[2:0]};
		task_out.xs   = 3'd0;
		task_out.xf   = tmb_rdata.xflp;
		task_out.pal  = {plane ? cfg.t1_palsel : cfg.t0_palsel, tmb_rdata.pal};
	end

endmodule

// ==== rtl/ts_regs.sv ====
`timescale 1ns/1ps

module ts_regs
	import ts_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output ts_cfg_t     cfg,
	output logic        sfile_we,
	output logic [7:0]  sfile_waddr,
	output sfile_word_t sfile_wdata,
	output logic        tmb_we,
	output logic [8:0]  tmb_waddr,
	output tile_desc_t  tmb_wdata
);

	logic       access;
	logic       cfg_hit;
	logic       sf_hit;
	logic       tmb_hit;
	logic [3:0] reg_idx;

	assign access  = psel && penable;
	assign reg_idx = paddr[5:2];
	// five config words at the bottom of the map
	assign cfg_hit = (paddr[11:6] == 6'd0) && (reg_idx < 4'd5);
	assign sf_hit  = (paddr[11:10] == 2'b01);
	assign tmb_hit = paddr[11];

	assign pready  = 1'b1;
	// RAM regions take writes only
	assign pslverr = access && !(cfg_hit || (pwrite && (sf_hit || tmb_hit)));

	assign sfile_we    = access && pwrite && sf_hit;
	assign sfile_waddr = paddr[9:2];
	assign sfile_wdata = pwdata[15:0];
	assign tmb_we      = access && pwrite && tmb_hit;
	assign tmb_waddr   = paddr[10:2];
	assign tmb_wdata   = tile_desc_t'(pwdata[15:0]);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cfg <= '0;
		else if (access && pwrite && cfg_hit)
		begin
			case (reg_idx)
				4'd0:
				begin
					cfg.s_en   <= pwdata[0];
					cfg.t0_en  <= pwdata[1];
					cfg.t1_en  <= pwdata[2];
					cfg.t0z_en <= pwdata[3];
					cfg.t1z_en <= pwdata[4];
				end
				4'd1:
				begin
					cfg.t0gpage <= pwdata[7:0];
					cfg.t1gpage <= pwdata[15:8];
					cfg.sgpage  <= pwdata[23:16];
				end
				4'd2: cfg.num_tiles <= pwdata[5:0];
				4'd3:
				begin
					cfg.t0x_offs  <= pwdata[8:0];
					cfg.t0y_offs  <= pwdata[18:16];
					cfg.t0_palsel <= pwdata[25:24];
				end
				default:
				begin
					cfg.t1x_offs  <= pwdata[8:0];
					cfg.t1y_offs  <= pwdata[18:16];
					cfg.t1_palsel <= pwdata[25:24];
				end
			endcase
		end
	end

	// read mux, zero outside the config words
	always_comb
	begin
		prdata = '0;
		if (access && !pwrite && cfg_hit)
		begin
			case (reg_idx)
				4'd0: prdata[4:0] = {cfg.t1z_en, cfg.t0z_en, cfg.t1_en, cfg.t0_en, cfg.s_en};
				4'd1: prdata[23:0] = {cfg.sgpage, cfg.t1gpage, cfg.t0gpage};
				4'd2: prdata[5:0] = cfg.num_tiles;
				4'd3: prdata[25:0] = {cfg.t0_palsel, 5'd0, cfg.t0y_offs, 7'd0, cfg.t0x_offs};
				default: prdata[25:0] = {cfg.t1_palsel, 5'd0, cfg.t1y_offs, 7'd0, cfg.t1x_offs};
			endcase
		end
	end

endmodule

// ==== rtl/ts_ram.sv ====
`timescale 1ns/1ps

module ts_ram #(
	parameter type entry_t = logic [15:0],
	parameter int DEPTH = 256,
	localparam int AW = $clog2(DEPTH)
)(
	input  logic          clk,
	input  logic          wr_en,
	input  logic [AW-1:0] wr_addr,
	input  entry_t        wr_data,
	input  logic [AW-1:0] rd_addr,
	output entry_t        rd_data
);

	entry_t mem [DEPTH];

	// registered read, one cycle of latency
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== rtl/ts_pkg.sv ====
package ts_pkg;

	// memory sizes
	localparam int SFILE_WORDS = 256;
	localparam int TMB_WORDS   = 512;
	localparam int LAST_SREG   = 254;

	// configuration registers
	typedef struct packed {
		logic       s_en;
		logic       t0_en;
		logic       t1_en;
		logic       t0z_en;
		logic       t1z_en;
		logic [7:0] t0gpage;
		logic [7:0] t1gpage;
		logic [7:0] sgpage;
		logic [5:0] num_tiles;
		logic [8:0] t0x_offs;
		logic [8:0] t1x_offs;
		logic [2:0] t0y_offs;
		logic [2:0] t1y_offs;
		logic [1:0] t0_palsel;
		logic [1:0] t1_palsel;
	} ts_cfg_t;

	// tilemap buffer entry
	typedef struct packed {
		logic        yflp;
		logic        xflp;
		logic [1:0]  pal;
		logic [11:0] tnum;
	} tile_desc_t;

	typedef logic [15:0] sfile_word_t;

	// sprite words, three per sprite
	typedef struct packed {
		logic       yflp;
		logic       leap;
		logic       act;
		logic       rsv;
		logic [2:0] ysz;
		logic [8:0] ycrd;
	} spr_r0_t;

	typedef struct packed {
		logic       xflp;
		logic [2:0] rsv;
		logic [2:0] xsz;
		logic [8:0] xcrd;
	} spr_r1_t;

	typedef struct packed {
		logic [3:0]  pal;
		logic [11:0] tnum;
	} spr_r2_t;

	// one task for the renderer
	typedef struct packed {
		logic [5:0] addr;
		logic [8:0] line;
		logic [7:0] page;
		logic [8:0] x;
		logic [2:0] xs;
		logic       xf;
		logic [3:0] pal;
	} tsr_task_t;

endpackage
